// File: hdl/meas_pkg.sv
`default_nettype none

package meas_pkg;

	// datapath widths
	localparam int DELAY_W     = 10;
	localparam int DAC_W       = 16;
	localparam int DAC_FRAME_W = 24;
	localparam int COUNT_W     = 16;

	// top byte of each dac frame: write input register, update output
	localparam logic [7:0] DAC_CMD_WRITE_UPDATE = 8'h30;

	////////////////////////////////////////////////////////////////////////////
	// register map, word index taken from address bits 4:2
	////////////////////////////////////////////////////////////////////////////

	localparam logic [2:0] REG_CTRL       = 3'd0;
	localparam logic [2:0] REG_STATUS     = 3'd1;
	localparam logic [2:0] REG_THRESH     = 3'd2;
	localparam logic [2:0] REG_CODE_START = 3'd3;
	localparam logic [2:0] REG_CODE_DELTA = 3'd4;
	localparam logic [2:0] REG_STEP_COUNT = 3'd5;
	// read only results
	localparam logic [2:0] REG_HIT_COUNT  = 3'd6;
	localparam logic [2:0] REG_FIRST_HIT  = 3'd7;

endpackage

`default_nettype wire

// File: hdl/meas_ctrl_if.sv
`default_nettype none

interface meas_ctrl_if;

	// configuration, owned by the register block
	logic                           start;
	logic [meas_pkg::DAC_W-1:0]     thresh;
	logic [meas_pkg::DELAY_W-1:0]   code_start;
	logic [meas_pkg::DELAY_W-1:0]   code_delta;
	logic [meas_pkg::COUNT_W-1:0]   step_count;

	// status and results, owned by the sweep engine
	logic                           busy;
	logic                           done_p;
	logic [meas_pkg::COUNT_W-1:0]   hit_count;
	logic [meas_pkg::DELAY_W-1:0]   first_hit;
	logic                           hit_valid;

	modport regs (
		output	start, thresh, code_start, code_delta, step_count,
		input	busy, done_p, hit_count, first_hit, hit_valid
	);

	modport engine (
		input	start, thresh, code_start, code_delta, step_count,
		output	busy, done_p, hit_count, first_hit, hit_valid
	);

endinterface

`default_nettype wire

// File: hdl/meas_wb_regs.sv
`default_nettype none

module meas_wb_regs (
	input	logic			hclk,
	input	logic			rst_i,
	input	logic			wb_cyc_i,
	input	logic			wb_stb_i,
	input	logic			wb_we_i,
	input	logic [31:0]	wb_adr_i,
	input	logic [31:0]	wb_dat_i,
	input	logic [3:0]		wb_sel_i,
	output	logic [31:0]	wb_dat_o,
	output	logic			wb_ack_o,
	output	logic			meas_done_o,
	meas_ctrl_if.regs		ctrl
);

	logic [2:0]		idx;
	logic			accept;
	logic			cfg_lock;
	logic			wr_en;
	logic [31:0]	rd_word;
	logic [31:0]	wr_word;

	// replace only the enabled byte lanes of the old word
	function automatic logic [31:0] lane_merge(
		input logic [31:0]	old_w,
		input logic [31:0]	new_w,
		input logic [3:0]	sel
	);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[b*8 +: 8] = new_w[b*8 +: 8];
		end
		return res;
	endfunction

	// classic cycle, stb is still up while ack is out
	assign accept   = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign idx      = wb_adr_i[4:2];
	// start already issued counts as busy
	assign cfg_lock = ctrl.busy || ctrl.start;
	assign wr_en    = accept && wb_we_i && !cfg_lock;
	assign wr_word  = lane_merge(rd_word, wb_dat_i, wb_sel_i);

	////////////////////////////////////////////////////////////////////////////
	// read mux
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_word = '0;
		case (idx)
			meas_pkg::REG_STATUS:
				rd_word[2:0] = {ctrl.hit_valid, meas_done_o, ctrl.busy};
			meas_pkg::REG_THRESH:
				rd_word[meas_pkg::DAC_W-1:0] = ctrl.thresh;
			meas_pkg::REG_CODE_START:
				rd_word[meas_pkg::DELAY_W-1:0] = ctrl.code_start;
			meas_pkg::REG_CODE_DELTA:
				rd_word[meas_pkg::DELAY_W-1:0] = ctrl.code_delta;
			meas_pkg::REG_STEP_COUNT:
				rd_word[meas_pkg::COUNT_W-1:0] = ctrl.step_count;
			meas_pkg::REG_HIT_COUNT:
				rd_word[meas_pkg::COUNT_W-1:0] = ctrl.hit_count;
			meas_pkg::REG_FIRST_HIT:
				rd_word[meas_pkg::DELAY_W-1:0] = ctrl.first_hit;
			default:
				rd_word = '0;
		endcase
	end

	always_ff @(posedge hclk) begin
		if (accept)
			wb_dat_o <= rd_word;
	end

	////////////////////////////////////////////////////////////////////////////
	// configuration registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge hclk) begin
		if (rst_i) begin
			ctrl.thresh     <= '0;
			ctrl.code_start <= '0;
			ctrl.code_delta <= '0;
			ctrl.step_count <= '0;
		end else if (wr_en) begin
			case (idx)
				meas_pkg::REG_THRESH:     ctrl.thresh     <= wr_word[meas_pkg::DAC_W-1:0];
				meas_pkg::REG_CODE_START: ctrl.code_start <= wr_word[meas_pkg::DELAY_W-1:0];
				meas_pkg::REG_CODE_DELTA: ctrl.code_delta <= wr_word[meas_pkg::DELAY_W-1:0];
				meas_pkg::REG_STEP_COUNT: ctrl.step_count <= wr_word[meas_pkg::COUNT_W-1:0];
				default: ;
			endcase
		end
	end

	// ack, start pulse and sticky done
	always_ff @(posedge hclk) begin
		if (rst_i) begin
			wb_ack_o    <= 1'b0;
			ctrl.start  <= 1'b0;
			meas_done_o <= 1'b0;
		end else begin
			wb_ack_o   <= accept;
			ctrl.start <= wr_en && (idx == meas_pkg::REG_CTRL) && wb_sel_i[0] && wb_dat_i[0];
			if (ctrl.start)
				meas_done_o <= 1'b0;
			else if (ctrl.done_p)
				meas_done_o <= 1'b1;
		end
	end

	ack_single: assert property (@(posedge hclk) disable iff (rst_i)
		wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire

// File: hdl/dac_spi_tx.sv
`default_nettype none

module dac_spi_tx #(
	parameter int DAC_SPI_CLK_DIV = 3
) (
	input	logic							hclk,
	input	logic							rst_i,
	input	logic							load_i,
	input	logic [meas_pkg::DAC_W-1:0]	data_i,
	output	logic							busy_o,
	output	logic							sync_o,
	output	logic							sclk_o,
	output	logic							sdi_o
);

	localparam int FW    = meas_pkg::DAC_FRAME_W;
	localparam int DIV_W = (DAC_SPI_CLK_DIV > 1) ? $clog2(DAC_SPI_CLK_DIV) : 1;
	localparam int BIT_W = $clog2(FW);

	logic [FW-1:0]		frame;
	logic [FW-1:0]		shreg;
	logic [DIV_W-1:0]	div_cnt;
	logic [BIT_W-1:0]	bit_cnt;
	logic				half_tick;
	logic				fin;

	// command byte on top, msb goes out first
	assign frame     = {meas_pkg::DAC_CMD_WRITE_UPDATE, data_i};
	assign half_tick = (div_cnt == DIV_W'(DAC_SPI_CLK_DIV - 1));

	always_ff @(posedge hclk) begin
		if (load_i && !busy_o)
			shreg <= {frame[FW-2:0], 1'b0};
		else if (busy_o && !fin && half_tick && sclk_o)
			shreg <= {shreg[FW-2:0], 1'b0};
	end

	////////////////////////////////////////////////////////////////////////////
	// sclk generation and bit sequencing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge hclk) begin
		if (rst_i) begin
			busy_o  <= 1'b0;
			sync_o  <= 1'b1;
			sclk_o  <= 1'b0;
			sdi_o   <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			fin     <= 1'b0;
		end else if (!busy_o) begin
			if (load_i) begin
				busy_o  <= 1'b1;
				sync_o  <= 1'b0;
				sdi_o   <= frame[FW-1];
				div_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (fin) begin
			// one cycle of hold after the last falling edge
			fin    <= 1'b0;
			sync_o <= 1'b1;
			busy_o <= 1'b0;
		end else if (half_tick) begin
			div_cnt <= '0;
			sclk_o  <= !sclk_o;
			if (sclk_o) begin
				// falling edge, next bit while sclk is low
				sdi_o   <= shreg[FW-1];
				bit_cnt <= bit_cnt + 1'b1;
				fin     <= (bit_cnt == BIT_W'(FW - 1));
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	sclk_in_frame: assert property (@(posedge hclk) disable iff (rst_i)
		$changed(sclk_o) |-> !sync_o);

endmodule

`default_nettype wire

// File: hdl/delay_sweep.sv
`default_nettype none

module delay_sweep #(
	parameter int DAC_SETTLE_CYCLES = 8
) (
	input	logic								hclk,
	input	logic								rst_i,
	meas_ctrl_if.engine						ctrl,
	input	logic								cmp_i,
	output	logic								dac_load_o,
	output	logic [meas_pkg::DAC_W-1:0]		dac_data_o,
	input	logic								dac_busy_i,
	output	logic [meas_pkg::DELAY_W-1:0]	delay_code_o,
	output	logic								stb_o
);

	localparam int SET_W = (DAC_SETTLE_CYCLES > 1) ? $clog2(DAC_SETTLE_CYCLES) : 1;

	localparam logic [2:0] S_IDLE     = 3'd0;
	localparam logic [2:0] S_LOAD     = 3'd1;
	localparam logic [2:0] S_WAIT_DAC = 3'd2;
	localparam logic [2:0] S_SETTLE   = 3'd3;
	localparam logic [2:0] S_STROBE   = 3'd4;
	localparam logic [2:0] S_SAMPLE   = 3'd5;
	localparam logic [2:0] S_NEXT     = 3'd6;

	logic [2:0]						state;
	logic [meas_pkg::COUNT_W-1:0]	step_cnt;
	logic [SET_W-1:0]				settle_cnt;
	logic							last_step;
	logic							settled;

	assign dac_load_o = (state == S_LOAD);
	assign dac_data_o = ctrl.thresh;
	assign stb_o      = (state == S_STROBE);
	assign ctrl.busy  = (state != S_IDLE);
	assign last_step  = (step_cnt == ctrl.step_count - 1'b1);
	assign settled    = (settle_cnt == SET_W'(DAC_SETTLE_CYCLES - 1));

	////////////////////////////////////////////////////////////////////////////
	// sweep fsm
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge hclk) begin
		if (rst_i) begin
			state          <= S_IDLE;
			step_cnt       <= '0;
			settle_cnt     <= '0;
			delay_code_o   <= '0;
			ctrl.done_p    <= 1'b0;
			ctrl.hit_count <= '0;
			ctrl.first_hit <= '0;
			ctrl.hit_valid <= 1'b0;
		end else begin
			ctrl.done_p <= 1'b0;
			case (state)
				S_IDLE: begin
					// results stay until the next start
					if (ctrl.start) begin
						ctrl.hit_count <= '0;
						ctrl.first_hit <= '0;
						ctrl.hit_valid <= 1'b0;
						state          <= S_LOAD;
					end
				end
				S_LOAD:
					state <= S_WAIT_DAC;
				S_WAIT_DAC: begin
					if (!dac_busy_i) begin
						if (ctrl.step_count == '0) begin
							ctrl.done_p <= 1'b1;
							state       <= S_IDLE;
						end else begin
							delay_code_o <= ctrl.code_start;
							step_cnt     <= '0;
							settle_cnt   <= '0;
							state        <= S_SETTLE;
						end
					end
				end
				S_SETTLE: begin
					if (settled)
						state <= S_STROBE;
					else
						settle_cnt <= settle_cnt + 1'b1;
				end
				S_STROBE:
					state <= S_SAMPLE;
				S_SAMPLE: begin
					// comparator is valid the cycle after the strobe
					if (cmp_i) begin
						ctrl.hit_count <= ctrl.hit_count + 1'b1;
						if (!ctrl.hit_valid) begin
							ctrl.first_hit <= delay_code_o;
							ctrl.hit_valid <= 1'b1;
						end
					end
					state <= S_NEXT;
				end
				S_NEXT: begin
					if (last_step) begin
						ctrl.done_p <= 1'b1;
						state       <= S_IDLE;
					end else begin
						step_cnt     <= step_cnt + 1'b1;
						// wraps modulo 1024
						delay_code_o <= delay_code_o + ctrl.code_delta;
						settle_cnt   <= '0;
						state        <= S_SETTLE;
					end
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	stb_not_during_dac: assert property (@(posedge hclk) disable iff (rst_i)
		stb_o |-> !dac_busy_i);

	stb_single: assert property (@(posedge hclk) disable iff (rst_i)
		stb_o |=> !stb_o);

endmodule

`default_nettype wire

// File: hdl/meas_top.sv
`default_nettype none

module meas_top #(
	parameter int DAC_SPI_CLK_DIV   = 3,
	parameter int DAC_SETTLE_CYCLES = 8
) (
	input	logic								hclk,
	input	logic								rst_i,
	// wishbone slave
	input	logic								wb_cyc_i,
	input	logic								wb_stb_i,
	input	logic								wb_we_i,
	input	logic [31:0]						wb_adr_i,
	input	logic [31:0]						wb_dat_i,
	input	logic [3:0]							wb_sel_i,
	output	logic [31:0]						wb_dat_o,
	output	logic								wb_ack_o,
	// comparator
	input	logic								cmp_i,
	// dac
	output	logic								dac_sync_o,
	output	logic								dac_sclk_o,
	output	logic								dac_sdi_o,
	// delay line
	output	logic [meas_pkg::DELAY_W-1:0]	delay_code_o,
	output	logic								stb_o,
	output	logic								meas_done_o
);

	logic							dac_load;
	logic [meas_pkg::DAC_W-1:0]	dac_data;
	logic							dac_busy;

	meas_ctrl_if ctrl_if ();

	meas_wb_regs meas_wb_regs_i (
		.hclk			(hclk),
		.rst_i			(rst_i),
		.wb_cyc_i		(wb_cyc_i),
		.wb_stb_i		(wb_stb_i),
		.wb_we_i		(wb_we_i),
		.wb_adr_i		(wb_adr_i),
		.wb_dat_i		(wb_dat_i),
		.wb_sel_i		(wb_sel_i),
		.wb_dat_o		(wb_dat_o),
		.wb_ack_o		(wb_ack_o),
		.meas_done_o	(meas_done_o),
		.ctrl			(ctrl_if.regs)
	);

	delay_sweep #(
		.DAC_SETTLE_CYCLES	(DAC_SETTLE_CYCLES)
	) delay_sweep_i (
		.hclk			(hclk),
		.rst_i			(rst_i),
		.ctrl			(ctrl_if.engine),
		.cmp_i			(cmp_i),
		.dac_load_o		(dac_load),
		.dac_data_o		(dac_data),
		.dac_busy_i		(dac_busy),
		.delay_code_o	(delay_code_o),
		.stb_o			(stb_o)
	);

	dac_spi_tx #(
		.DAC_SPI_CLK_DIV	(DAC_SPI_CLK_DIV)
	) dac_spi_tx_i (
		.hclk		(hclk),
		.rst_i		(rst_i),
		.load_i		(dac_load),
		.data_i		(dac_data),
		.busy_o		(dac_busy),
		.sync_o		(dac_sync_o),
		.sclk_o		(dac_sclk_o),
		.sdi_o		(dac_sdi_o)
	);

endmodule

`default_nettype wire

// File: sim/meas_tb.sv
`default_nettype none

module meas_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ACK_TMO  = 20;
	localparam int POLL_TMO = 2000;

	logic			hclk;
	logic			rst_i;
	logic			wb_cyc_i;
	logic			wb_stb_i;
	logic			wb_we_i;
	logic [31:0]	wb_adr_i;
	logic [31:0]	wb_dat_i;
	logic [3:0]		wb_sel_i;
	logic [31:0]	wb_dat_o;
	logic			wb_ack_o;
	logic			cmp_i;
	logic			dac_sync_o;
	logic			dac_sclk_o;
	logic			dac_sdi_o;
	logic [9:0]		delay_code_o;
	logic			stb_o;
	logic			meas_done_o;

	int				errors = 0;
	int				tests_passed = 0;
	int				tests_failed = 0;
	int				stb_cnt = 0;
	int				frame_cnt = 0;
	int				frame_bits = 0;
	int				spi_bits = 0;
	logic [23:0]	spi_shift = '0;
	logic [23:0]	spi_frame = '0;
	logic [31:0]	seed = 32'h5a616586;

	meas_top meas_top_i (
		.hclk			(hclk),
		.rst_i			(rst_i),
		.wb_cyc_i		(wb_cyc_i),
		.wb_stb_i		(wb_stb_i),
		.wb_we_i		(wb_we_i),
		.wb_adr_i		(wb_adr_i),
		.wb_dat_i		(wb_dat_i),
		.wb_sel_i		(wb_sel_i),
		.wb_dat_o		(wb_dat_o),
		.wb_ack_o		(wb_ack_o),
		.cmp_i			(cmp_i),
		.dac_sync_o		(dac_sync_o),
		.dac_sclk_o		(dac_sclk_o),
		.dac_sdi_o		(dac_sdi_o),
		.delay_code_o	(delay_code_o),
		.stb_o			(stb_o),
		.meas_done_o	(meas_done_o)
	);

	always #20 hclk = ~hclk;

	// comparator trips at the top 10 bits of the last dac word
	always @(posedge hclk) begin
		cmp_i <= (delay_code_o >= spi_frame[15:6]);
	end

	always @(posedge hclk) begin
		if (stb_o)
			stb_cnt <= stb_cnt + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// spi monitor, dac samples on the rising sclk edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge dac_sync_o) begin
		spi_bits <= 0;
	end

	always @(posedge dac_sclk_o) begin
		if (!dac_sync_o) begin
			spi_shift <= {spi_shift[22:0], dac_sdi_o};
			spi_bits  <= spi_bits + 1;
		end
	end

	always @(posedge dac_sync_o) begin
		spi_frame  <= spi_shift;
		frame_bits <= spi_bits;
		frame_cnt  <= frame_cnt + 1;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// expected sweep result from the step rule and the comparator model
	function automatic void ref_sweep(input logic [15:0] th, input logic [9:0] cs,
			input logic [9:0] cd, input logic [15:0] sc, output logic [15:0] hits,
			output logic [9:0] first, output logic valid);
		logic [9:0] code;
		hits  = '0;
		first = '0;
		valid = 1'b0;
		code  = cs;
		for (int k = 0; k < int'(sc); k++) begin
			if (code >= th[15:6]) begin
				hits = hits + 16'd1;
				if (!valid) begin
					first = code;
					valid = 1'b1;
				end
			end
			code = code + cd;
		end
	endfunction

	task automatic report_fail(input string msg);
		$display("Fail at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic end_test(input string name, input int err0);
		if (errors == err0) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: FAILED", name);
			tests_failed++;
		end
	endtask

	task automatic wb_access(input logic we, input logic [2:0] idx, input logic [31:0] data,
			input logic [3:0] sel, output logic [31:0] rdata);
		int n;
		@(posedge hclk);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= {27'h0, idx, 2'b00};
		wb_dat_i <= data;
		wb_sel_i <= sel;
		n = 0;
		do begin
			@(negedge hclk);
			n++;
		end while (!wb_ack_o && n < ACK_TMO);
		rdata = wb_dat_o;
		if (!wb_ack_o) begin
			$display("no ack from the slave within %0d cycles at %0d ns", ACK_TMO, $time);
			errors++;
		end else if (n != 2) begin
			report_fail($sformatf("ack came %0d cycles after request, expected 1", n - 1));
		end
		@(posedge hclk);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
		@(negedge hclk);
		if (wb_ack_o)
			report_fail("ack stayed high for a second cycle");
	endtask

	task automatic reg_write(input logic [2:0] idx, input logic [31:0] data,
			input logic [3:0] sel);
		logic [31:0] dummy;
		wb_access(1'b1, idx, data, sel, dummy);
	endtask

	task automatic reg_read(input logic [2:0] idx, output logic [31:0] data);
		wb_access(1'b0, idx, 32'h0, 4'hf, data);
	endtask

	task automatic write_then_check(input logic [2:0] idx, input logic [31:0] data,
			input logic [3:0] sel, input logic [31:0] exp);
		logic [31:0] rd;
		reg_write(idx, data, sel);
		reg_read(idx, rd);
		if (rd !== exp)
			report_fail($sformatf("reg %0d read %h, expected %h", idx, rd, exp));
	endtask

	task automatic start_sweep(input logic [15:0] th, input logic [9:0] cs,
			input logic [9:0] cd, input logic [15:0] sc);
		reg_write(meas_pkg::REG_THRESH, {16'h0, th}, 4'hf);
		reg_write(meas_pkg::REG_CODE_START, {22'h0, cs}, 4'hf);
		reg_write(meas_pkg::REG_CODE_DELTA, {22'h0, cd}, 4'hf);
		reg_write(meas_pkg::REG_STEP_COUNT, {16'h0, sc}, 4'hf);
		reg_write(meas_pkg::REG_CTRL, 32'h1, 4'hf);
	endtask

	task automatic finish_sweep(input logic [15:0] th, input logic [9:0] cs,
			input logic [9:0] cd, input logic [15:0] sc, input int stb0, input int frm0);
		logic [31:0]	rd;
		logic [15:0]	e_hits;
		logic [9:0]		e_first;
		logic			e_valid;
		int				polls;
		rd    = '0;
		polls = 0;
		while (!rd[1] && polls < POLL_TMO) begin
			reg_read(meas_pkg::REG_STATUS, rd);
			polls++;
		end
		if (!rd[1]) begin
			$display("sweep did not finish within %0d status polls", POLL_TMO);
			errors++;
		end
		ref_sweep(th, cs, cd, sc, e_hits, e_first, e_valid);
		if (rd[2:0] !== {e_valid, 2'b10})
			report_fail($sformatf("status %b, expected %b", rd[2:0], {e_valid, 2'b10}));
		if (!meas_done_o)
			report_fail("meas_done_o low after the sweep");
		reg_read(meas_pkg::REG_HIT_COUNT, rd);
		if (rd !== {16'h0, e_hits})
			report_fail($sformatf("hit count %0d, expected %0d", rd, e_hits));
		reg_read(meas_pkg::REG_FIRST_HIT, rd);
		if (e_valid && rd !== {22'h0, e_first})
			report_fail($sformatf("first hit %0d, expected %0d", rd, e_first));
		if (stb_cnt - stb0 != int'(sc))
			report_fail($sformatf("%0d strobes, expected %0d", stb_cnt - stb0, sc));
		if (frame_cnt - frm0 != 1)
			report_fail($sformatf("%0d dac frames in one sweep", frame_cnt - frm0));
		if (spi_frame !== {meas_pkg::DAC_CMD_WRITE_UPDATE, th} || frame_bits != 24)
			report_fail($sformatf("dac frame %h with %0d bits", spi_frame, frame_bits));
		if (!dac_sync_o)
			report_fail("dac_sync_o low after the frame");
	endtask

	task automatic run_sweep(input logic [15:0] th, input logic [9:0] cs,
			input logic [9:0] cd, input logic [15:0] sc);
		int stb0;
		int frm0;
		stb0 = stb_cnt;
		frm0 = frame_cnt;
		start_sweep(th, cs, cd, sc);
		finish_sweep(th, cs, cd, sc, stb0, frm0);
	endtask

	initial begin
		logic [31:0]	rd;
		logic [15:0]	th;
		logic [15:0]	sc;
		logic [9:0]		cs;
		logic [9:0]		cd;
		int				err0;
		int				stb0;
		int				frm0;
		hclk     = 1'b0;
		rst_i    = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_sel_i = '0;
		cmp_i    = 1'b0;
		repeat (5) @(posedge hclk);
		rst_i <= 1'b0;

		err0 = errors;
		write_then_check(meas_pkg::REG_THRESH, 32'hdead_beef, 4'hf, 32'h0000_beef);
		write_then_check(meas_pkg::REG_CODE_START, 32'hffff_ffff, 4'hf, 32'h0000_03ff);
		write_then_check(meas_pkg::REG_CODE_DELTA, 32'h1234_5678, 4'hf, 32'h0000_0278);
		write_then_check(meas_pkg::REG_STEP_COUNT, 32'h0001_2345, 4'hf, 32'h0000_2345);
		// single lanes
		write_then_check(meas_pkg::REG_THRESH, 32'h0000_1100, 4'b0010, 32'h0000_11ef);
		write_then_check(meas_pkg::REG_STEP_COUNT, 32'h0000_00aa, 4'b0001, 32'h0000_23aa);
		end_test("register access", err0);

		err0 = errors;
		run_sweep(16'ha5c3, 10'd0, 10'd1, 16'd1);
		end_test("dac frame", err0);

		err0 = errors;
		run_sweep(16'h6400, 10'd380, 10'd4, 16'd12);
		end_test("directed sweep", err0);

		err0 = errors;
		for (int i = 0; i < 8; i++) begin
			seed = lcg_next(seed);
			th   = seed[31:16];
			seed = lcg_next(seed);
			cs   = seed[25:16];
			seed = lcg_next(seed);
			cd   = seed[25:16];
			seed = lcg_next(seed);
			sc   = {11'h0, seed[20:16]} + 16'd1;
			if (i == 0) begin
				// crosses 1023
				cs = 10'd1015;
				cd = 10'd3;
				sc = 16'd10;
			end
			run_sweep(th, cs, cd, sc);
		end
		end_test("random sweeps", err0);

		err0 = errors;
		run_sweep(16'hffff, 10'd0, 10'd1, 16'd50);
		run_sweep(16'h0000, 10'd5, 10'd1, 16'd0);
		reg_read(meas_pkg::REG_STATUS, rd);
		if (rd[2] !== 1'b0)
			report_fail("hit_valid set after a sweep of zero steps");
		reg_read(meas_pkg::REG_HIT_COUNT, rd);
		if (rd !== 32'h0)
			report_fail($sformatf("hit count %0d after a sweep of zero steps", rd));
		end_test("no-hit sweeps", err0);

		err0 = errors;
		stb0 = stb_cnt;
		frm0 = frame_cnt;
		start_sweep(16'h4000, 10'd250, 10'd1, 16'd20);
		reg_write(meas_pkg::REG_THRESH, 32'h0000_0123, 4'hf);
		reg_write(meas_pkg::REG_CTRL, 32'h1, 4'hf);
		reg_read(meas_pkg::REG_THRESH, rd);
		if (rd !== 32'h0000_4000)
			report_fail($sformatf("thresh changed to %h during a sweep", rd));
		finish_sweep(16'h4000, 10'd250, 10'd1, 16'd20, stb0, frm0);
		repeat (10) @(posedge hclk);
		reg_read(meas_pkg::REG_STATUS, rd);
		if (rd[1:0] !== 2'b10)
			report_fail($sformatf("status %b after the dropped start", rd[2:0]));
		end_test("busy protection", err0);

		$display("%0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
hdl/meas_pkg.sv
hdl/meas_ctrl_if.sv
hdl/meas_wb_regs.sv
hdl/dac_spi_tx.sv
hdl/delay_sweep.sv
hdl/meas_top.sv
sim/meas_tb.sv

// File: Makefile
# Verilator flow for the measurement block
# usage: make lint | make sim | make clean

VERILATOR ?= verilator
TOP       ?= meas_tb
RTL_TOP   ?= meas_top
FILELIST  ?= build.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
